/* spw_tx_pkg.sv */
package spw_tx_pkg;

	// Payload and host word widths
	localparam int DATA_W = 8;
	localparam int HOST_W = 9;

	// Control codes, sent least significant bit first
	localparam logic [1:0] CTRL_FCT = 2'b00;
	localparam logic [1:0] CTRL_EOP = 2'b01;
	localparam logic [1:0] CTRL_EEP = 2'b10;
	localparam logic [1:0] CTRL_ESC = 2'b11;

	// Character lengths on the line
	localparam int CNT_W = 4;
	localparam logic [CNT_W-1:0] LEN_DATA = 4'd10;
	localparam logic [CNT_W-1:0] LEN_CTRL = 4'd4;
	localparam logic [CNT_W-1:0] LEN_NULL = 4'd8;

	// Flow control
	localparam int CREDIT_W = 6;
	localparam logic [CREDIT_W-1:0] CREDIT_STEP = 6'd8;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 6'd56;
	localparam int OWED_W = 3;
	localparam logic [OWED_W-1:0] OWED_INIT = 3'd7;

	typedef enum logic [2:0] {
		CH_NULL,
		CH_FCT,
		CH_DATA,
		CH_EOP,
		CH_EEP
	} char_kind_t;

	// One queued character, 11 bits
	typedef struct packed {
		char_kind_t kind;
		logic [DATA_W-1:0] data;
	} tx_char_t;

	typedef enum logic [1:0] {
		START,
		NULL_ONLY,
		NULL_FCT,
		RUN
	} link_state_t;

endpackage

/* char_if.sv */
`timescale 1ns/1ps

interface char_if;

	// Write side
	logic push;
	spw_tx_pkg::tx_char_t push_char;
	logic full;

	// Read side, pop_char shows the oldest entry
	logic pop;
	spw_tx_pkg::tx_char_t pop_char;
	logic empty;

	modport producer (output push, output push_char, input full);
	modport buffer (input push, input push_char, input pop,
		output full, output pop_char, output empty);
	modport consumer (output pop, input pop_char, input empty);

endinterface

/* spw_tx_scheduler.sv */
`timescale 1ns/1ps

module spw_tx_scheduler (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic [spw_tx_pkg::HOST_W-1:0] data_tx_i,
	input  logic txwrite_tx_i,
	input  logic send_null_tx_i,
	input  logic send_fct_tx_i,
	input  logic gotfct_tx_i,
	input  logic send_fct_now_i,
	output logic ready_tx_data_o,
	char_if.producer chars_o
);

	spw_tx_pkg::link_state_t state_q;
	spw_tx_pkg::link_state_t state_d;
	logic [spw_tx_pkg::CREDIT_W-1:0] credit_q;
	logic [spw_tx_pkg::CREDIT_W-1:0] credit_d;
	logic [spw_tx_pkg::OWED_W-1:0] owed_q;
	logic [spw_tx_pkg::OWED_W-1:0] owed_d;
	logic gotfct_q;
	logic fct_now_q;
	logic gotfct_rise;
	logic fct_now_rise;
	logic sel_valid;
	spw_tx_pkg::tx_char_t sel_char;
	spw_tx_pkg::tx_char_t host_char;
	logic push_fct;
	logic push_host;

	assign gotfct_rise = gotfct_tx_i & ~gotfct_q;
	assign fct_now_rise = send_fct_now_i & ~fct_now_q;

	// Host word to character
	always_comb
	begin
		host_char.data = data_tx_i[spw_tx_pkg::DATA_W-1:0];
		host_char.kind = spw_tx_pkg::CH_DATA;
		if (data_tx_i[spw_tx_pkg::HOST_W-1])
		begin
			host_char.data = '0;
			if (data_tx_i[1:0] == 2'b00)
				host_char.kind = spw_tx_pkg::CH_EOP;
			else
				host_char.kind = spw_tx_pkg::CH_EEP;
		end
	end

	// --------------------------------------------------
	// Next character and link state
	// --------------------------------------------------
	always_comb
	begin
		sel_valid = 1'b0;
		sel_char.kind = spw_tx_pkg::CH_NULL;
		sel_char.data = '0;
		state_d = state_q;
		case (state_q)
			spw_tx_pkg::START:
			begin
				if (send_null_tx_i)
					state_d = spw_tx_pkg::NULL_ONLY;
			end
			spw_tx_pkg::NULL_ONLY:
			begin
				sel_valid = 1'b1;
				if (send_fct_tx_i)
					state_d = spw_tx_pkg::NULL_FCT;
			end
			spw_tx_pkg::NULL_FCT:
			begin
				sel_valid = 1'b1;
				if (owed_q != '0)
					sel_char.kind = spw_tx_pkg::CH_FCT;
				if (send_fct_tx_i && credit_q != '0)
					state_d = spw_tx_pkg::RUN;
			end
			default:
			begin
				sel_valid = 1'b1;
				// FCT first, then host data, then filler NULL
				if (owed_q != '0)
					sel_char.kind = spw_tx_pkg::CH_FCT;
				else if (txwrite_tx_i && credit_q != '0 && !ready_tx_data_o)
					sel_char = host_char;
			end
		endcase
	end

	assign chars_o.push = sel_valid & ~chars_o.full;
	assign chars_o.push_char = sel_char;
	assign push_fct = chars_o.push && sel_char.kind == spw_tx_pkg::CH_FCT;
	assign push_host = chars_o.push && (sel_char.kind == spw_tx_pkg::CH_DATA ||
		sel_char.kind == spw_tx_pkg::CH_EOP || sel_char.kind == spw_tx_pkg::CH_EEP);

	// Credit and owed FCT counts, edge events are taken even while stalled
	always_comb
	begin
		credit_d = credit_q - {{(spw_tx_pkg::CREDIT_W-1){1'b0}}, push_host};
		if (gotfct_rise)
		begin
			if (credit_d > spw_tx_pkg::CREDIT_MAX - spw_tx_pkg::CREDIT_STEP)
				credit_d = spw_tx_pkg::CREDIT_MAX;
			else
				credit_d = credit_d + spw_tx_pkg::CREDIT_STEP;
		end
		owed_d = owed_q - {{(spw_tx_pkg::OWED_W-1){1'b0}}, push_fct};
		if (fct_now_rise && owed_d != {spw_tx_pkg::OWED_W{1'b1}})
			owed_d = owed_d + 1'b1;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state_q <= spw_tx_pkg::START;
			credit_q <= '0;
			owed_q <= spw_tx_pkg::OWED_INIT;
			gotfct_q <= 1'b0;
			fct_now_q <= 1'b0;
			ready_tx_data_o <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			credit_q <= credit_d;
			owed_q <= owed_d;
			gotfct_q <= gotfct_tx_i;
			fct_now_q <= send_fct_now_i;
			ready_tx_data_o <= push_host;
		end
	end

endmodule

/* spw_char_fifo.sv */
`timescale 1ns/1ps

module spw_char_fifo #(
	parameter int DEPTH = 2
) (
	input  logic pclk_tx,
	input  logic enable_tx,
	char_if.buffer chars
);

	spw_tx_pkg::tx_char_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	assign chars.full = (int'(count) == DEPTH);
	assign chars.empty = (count == '0);
	assign chars.pop_char = mem[rd_ptr];

	// Storage
	always_ff @(posedge pclk_tx)
	begin
		if (chars.push)
			mem[wr_ptr] <= chars.push_char;
	end

	// Pointers wrap at DEPTH
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (chars.push)
				wr_ptr <= (int'(wr_ptr) == DEPTH-1) ? '0 : wr_ptr + 1'b1;
			if (chars.pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH-1) ? '0 : rd_ptr + 1'b1;
			if (chars.push && !chars.pop)
				count <= count + 1'b1;
			else if (chars.pop && !chars.push)
				count <= count - 1'b1;
		end
	end

endmodule

/* spw_tx_serializer.sv */
`timescale 1ns/1ps

module spw_tx_serializer (
	input  logic pclk_tx,
	input  logic enable_tx,
	output logic tx_dout_e_o,
	output logic tx_sout_e_o,
	char_if.consumer chars_i
);

	logic busy_q;
	logic [spw_tx_pkg::CNT_W-1:0] cnt_q;
	logic [9:0] shift_q;
	logic prev_par_q;
	logic [9:0] frame_new;
	logic [spw_tx_pkg::CNT_W-1:0] len_new;
	logic par_new;
	logic [1:0] code;
	logic drive;
	logic next_bit;

	// --------------------------------------------------
	// Frame build with bit 0 going out first
	// --------------------------------------------------
	always_comb
	begin
		case (chars_i.pop_char.kind)
			spw_tx_pkg::CH_EOP: code = spw_tx_pkg::CTRL_EOP;
			spw_tx_pkg::CH_EEP: code = spw_tx_pkg::CTRL_EEP;
			default: code = spw_tx_pkg::CTRL_FCT;
		endcase
		case (chars_i.pop_char.kind)
			spw_tx_pkg::CH_DATA:
			begin
				frame_new = {chars_i.pop_char.data, 1'b0, ~prev_par_q};
				len_new = spw_tx_pkg::LEN_DATA;
				par_new = ^chars_i.pop_char.data;
			end
			spw_tx_pkg::CH_NULL:
			begin
				// Parity of the FCT half of a NULL covers the ESC code
				frame_new = {2'b00, spw_tx_pkg::CTRL_FCT, 1'b1,
					~(^spw_tx_pkg::CTRL_ESC ^ 1'b1),
					spw_tx_pkg::CTRL_ESC, 1'b1, ~(prev_par_q ^ 1'b1)};
				len_new = spw_tx_pkg::LEN_NULL;
				par_new = ^spw_tx_pkg::CTRL_FCT;
			end
			default:
			begin
				frame_new = {6'b000000, code, 1'b1, ~(prev_par_q ^ 1'b1)};
				len_new = spw_tx_pkg::LEN_CTRL;
				par_new = ^code;
			end
		endcase
	end

	// Pop when idle or on the last bit
	assign chars_i.pop = (!busy_q || cnt_q == '0) && !chars_i.empty;
	assign drive = chars_i.pop || (busy_q && cnt_q != '0);
	assign next_bit = chars_i.pop ? frame_new[0] : shift_q[0];

	always_ff @(posedge pclk_tx)
	begin
		if (chars_i.pop)
			shift_q <= frame_new >> 1;
		else if (busy_q)
			shift_q <= shift_q >> 1;
	end

	// --------------------------------------------------
	// Bit counter and data-strobe output
	// --------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			prev_par_q <= 1'b0;
			tx_dout_e_o <= 1'b0;
			tx_sout_e_o <= 1'b0;
		end
		else
		begin
			if (drive)
			begin
				tx_dout_e_o <= next_bit;
				// Strobe toggles when data repeats
				tx_sout_e_o <= (next_bit == tx_dout_e_o) ? ~tx_sout_e_o : tx_sout_e_o;
			end
			if (chars_i.pop)
			begin
				busy_q <= 1'b1;
				cnt_q <= len_new - 1'b1;
				prev_par_q <= par_new;
			end
			else if (busy_q)
			begin
				if (cnt_q == '0)
					busy_q <= 1'b0;
				else
					cnt_q <= cnt_q - 1'b1;
			end
		end
	end

endmodule

/* spw_tx_top.sv */
`timescale 1ns/1ps

module spw_tx_top (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic [spw_tx_pkg::HOST_W-1:0] data_tx_i,
	input  logic txwrite_tx_i,
	input  logic send_null_tx_i,
	input  logic send_fct_tx_i,
	input  logic gotfct_tx_i,
	input  logic send_fct_now_i,
	output logic tx_dout_e_o,
	output logic tx_sout_e_o,
	output logic ready_tx_data_o
);

	// Character path between the three stages
	char_if chars ();

	spw_tx_scheduler u_scheduler (
		.pclk_tx         (pclk_tx),
		.enable_tx       (enable_tx),
		.data_tx_i       (data_tx_i),
		.txwrite_tx_i    (txwrite_tx_i),
		.send_null_tx_i  (send_null_tx_i),
		.send_fct_tx_i   (send_fct_tx_i),
		.gotfct_tx_i     (gotfct_tx_i),
		.send_fct_now_i  (send_fct_now_i),
		.ready_tx_data_o (ready_tx_data_o),
		.chars_o         (chars)
	);

	spw_char_fifo #(
		.DEPTH (2)
	) u_fifo (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.chars     (chars)
	);

	spw_tx_serializer u_serializer (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.tx_dout_e_o (tx_dout_e_o),
		.tx_sout_e_o (tx_sout_e_o),
		.chars_i     (chars)
	);

endmodule

/* spw_tx_properties.sv */
`timescale 1ns/1ps

module spw_tx_properties (
	input logic pclk_tx,
	input logic enable_tx,
	input logic dout_i,
	input logic sout_i,
	input logic push_i,
	input logic full_i
);

	// Count of assertion failures
	int fails = 0;

	// Data-strobe encoding moves one line per bit
	a_one_line: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		($changed(dout_i) || $changed(sout_i)) |-> ($changed(dout_i) != $changed(sout_i)))
	else
	begin
		$error("both data and strobe changed in one bit period");
		fails++;
	end

	// Buffer overflow guard
	a_no_push_full: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		push_i |-> !full_i)
	else
	begin
		$error("push issued while the character buffer is full");
		fails++;
	end

endmodule

bind spw_tx_top spw_tx_properties u_props (
	.pclk_tx   (pclk_tx),
	.enable_tx (enable_tx),
	.dout_i    (tx_dout_e_o),
	.sout_i    (tx_sout_e_o),
	.push_i    (chars.push),
	.full_i    (chars.full)
);

/* tb_spw_tx.sv */
`timescale 1ns/1ps

module tb_spw_tx;

	localparam int MAX_REC = 64;
	localparam int READY_WAIT = 64;
	localparam int STALL_CYCLES = 32;

	// Decoded character codes above the data range 000 to 0ff
	localparam logic [11:0] K_EOP = 12'h101;
	localparam logic [11:0] K_EEP = 12'h102;
	localparam logic [11:0] K_FCT = 12'h103;
	localparam logic [11:0] K_NULL = 12'h104;
	localparam logic [11:0] K_NONE = 12'hfff;

	logic pclk_tx;
	logic enable_tx;
	logic [spw_tx_pkg::HOST_W-1:0] data_tx_i;
	logic txwrite_tx_i;
	logic send_null_tx_i;
	logic send_fct_tx_i;
	logic gotfct_tx_i;
	logic send_fct_now_i;
	logic tx_dout_e_o;
	logic tx_sout_e_o;
	logic ready_tx_data_o;

	// Stim records
	string rec_name [MAX_REC];
	string rec_act [MAX_REC];
	logic [11:0] rec_val [MAX_REC];
	logic [11:0] rec_exp [MAX_REC][4];
	int rec_err [MAX_REC];
	int exp_left [MAX_REC];
	bit act_done [MAX_REC];
	bit reported [MAX_REC];
	int nrec;

	// Pending expected characters in line order
	logic [11:0] exp_code [$];
	int exp_rec [$];

	int errors;
	int limit;
	int cycles;
	int ready_count;
	int write_count;

	// Line decoder state
	logic last_x;
	logic [9:0] sh;
	int nb;
	logic prev_pay;
	bit esc_pend;

	spw_tx_top UUT (
		.pclk_tx         (pclk_tx),
		.enable_tx       (enable_tx),
		.data_tx_i       (data_tx_i),
		.txwrite_tx_i    (txwrite_tx_i),
		.send_null_tx_i  (send_null_tx_i),
		.send_fct_tx_i   (send_fct_tx_i),
		.gotfct_tx_i     (gotfct_tx_i),
		.send_fct_now_i  (send_fct_now_i),
		.tx_dout_e_o     (tx_dout_e_o),
		.tx_sout_e_o     (tx_sout_e_o),
		.ready_tx_data_o (ready_tx_data_o)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever #2 pclk_tx = ~pclk_tx;
	end

	// Watchdog
	always @(posedge pclk_tx)
	begin
		cycles++;
		if (limit > 0 && cycles > limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("Test failed");
			$finish;
		end
	end

	always @(negedge pclk_tx)
	begin
		if (ready_tx_data_o)
			ready_count++;
	end

	task automatic finish_record(input int idx);
		if (act_done[idx] && exp_left[idx] == 0 && !reported[idx])
		begin
			reported[idx] = 1'b1;
			if (rec_err[idx] == 0)
				$display("%s %s: ok", rec_name[idx], rec_act[idx]);
			else
				$display("%s %s: %0d error(s)", rec_name[idx], rec_act[idx], rec_err[idx]);
		end
	endtask

	task automatic note_failure(input int idx, input string msg);
		$display("%s: %s", rec_name[idx], msg);
		errors++;
		rec_err[idx]++;
	endtask

	// Compare one decoded character against the pending list
	task automatic match_char(input logic [11:0] got);
		logic [11:0] want;
		int idx;
		if (exp_code.size() == 0)
		begin
			assert (got == K_NULL)
			else
			begin
				$display("Character %h appeared with nothing expected", got);
				errors++;
			end
		end
		else
		begin
			want = exp_code[0];
			idx = exp_rec[0];
			// Filler NULLs may precede any other character
			if (!(want != K_NULL && got == K_NULL))
			begin
				want = exp_code.pop_front();
				idx = exp_rec.pop_front();
				assert (got == want)
				else
				begin
					$display("[ERROR] %s: expected %h, actual %h", rec_name[idx], want, got);
					errors++;
					rec_err[idx]++;
				end
				exp_left[idx]--;
				finish_record(idx);
			end
		end
	endtask

	task automatic take_char();
		logic flag;
		logic [1:0] code;
		flag = sh[1];
		code = {sh[3], sh[2]};
		assert (sh[0] == ~(prev_pay ^ flag))
		else
		begin
			$display("Parity bit wrong on the line after %0d bits", nb);
			errors++;
		end
		prev_pay = flag ? ^code : ^sh[9:2];
		if (!flag)
			match_char({4'h0, sh[9:2]});
		else if (code == spw_tx_pkg::CTRL_ESC)
			esc_pend = 1'b1;
		else if (esc_pend)
		begin
			esc_pend = 1'b0;
			assert (code == spw_tx_pkg::CTRL_FCT)
			else
			begin
				$display("ESC followed by something other than FCT");
				errors++;
			end
			match_char(K_NULL);
		end
		else if (code == spw_tx_pkg::CTRL_FCT)
			match_char(K_FCT);
		else if (code == spw_tx_pkg::CTRL_EOP)
			match_char(K_EOP);
		else
			match_char(K_EEP);
	endtask

	// --------------------------------------------------
	// Data-strobe decoder takes one bit per change of d^s
	// --------------------------------------------------
	always @(negedge pclk_tx)
	begin
		if (!enable_tx)
		begin
			last_x = 1'b0;
			nb = 0;
			prev_pay = 1'b0;
			esc_pend = 1'b0;
		end
		else if ((tx_dout_e_o ^ tx_sout_e_o) != last_x)
		begin
			last_x = tx_dout_e_o ^ tx_sout_e_o;
			sh[nb] = tx_dout_e_o;
			nb++;
			if ((nb == 4 && sh[1]) || nb == 10)
			begin
				take_char();
				nb = 0;
			end
		end
	end

	task automatic read_stim();
		int fd;
		int n;
		string line;
		string name;
		string act;
		logic [11:0] v;
		logic [11:0] e0;
		logic [11:0] e1;
		logic [11:0] e2;
		logic [11:0] e3;
		nrec = 0;
		fd = $fopen("tx_stim.txt", "r");
		if (fd == 0)
			$display("Cannot open the stim file tx_stim.txt");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				n = $sscanf(line, "%s %s %h %h %h %h %h", name, act, v, e0, e1, e2, e3);
				if (n == 7 && nrec < MAX_REC)
				begin
					rec_name[nrec] = name;
					rec_act[nrec] = act;
					rec_val[nrec] = v;
					rec_exp[nrec][0] = e0;
					rec_exp[nrec][1] = e1;
					rec_exp[nrec][2] = e2;
					rec_exp[nrec][3] = e3;
					nrec++;
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------------------------------------
	// One stim record
	// --------------------------------------------------
	task automatic run_record(input int i);
		int guard;
		for (int k = 0; k < 4; k++)
		begin
			if (rec_exp[i][k] != K_NONE)
			begin
				exp_code.push_back(rec_exp[i][k]);
				exp_rec.push_back(i);
				exp_left[i]++;
			end
		end
		if (rec_act[i] == "quiet")
		begin
			repeat (rec_val[i])
			begin
				@(negedge pclk_tx);
				assert (tx_dout_e_o == 1'b0 && tx_sout_e_o == 1'b0)
				else note_failure(i, "line moved before send_null was raised");
			end
		end
		else if (rec_act[i] == "send_null")
		begin
			send_null_tx_i = 1'b1;
			@(negedge pclk_tx);
		end
		else if (rec_act[i] == "send_fct")
		begin
			send_fct_tx_i = 1'b1;
			@(negedge pclk_tx);
		end
		else if (rec_act[i] == "gotfct")
		begin
			gotfct_tx_i = 1'b1;
			@(negedge pclk_tx);
			gotfct_tx_i = 1'b0;
		end
		else if (rec_act[i] == "fct_now")
		begin
			send_fct_now_i = 1'b1;
			@(negedge pclk_tx);
			send_fct_now_i = 1'b0;
		end
		else if (rec_act[i] == "wait")
		begin
			repeat (rec_val[i]) @(negedge pclk_tx);
		end
		else if (rec_act[i] == "write")
		begin
			data_tx_i = rec_val[i][8:0];
			txwrite_tx_i = 1'b1;
			guard = 0;
			do
			begin
				@(negedge pclk_tx);
				guard++;
			end
			while (!ready_tx_data_o && guard < READY_WAIT);
			assert (ready_tx_data_o)
			else note_failure(i, "host word was never taken");
			txwrite_tx_i = 1'b0;
			write_count++;
		end
		else if (rec_act[i] == "stall")
		begin
			// A word offered without credit is not taken
			data_tx_i = rec_val[i][8:0];
			txwrite_tx_i = 1'b1;
			repeat (STALL_CYCLES)
			begin
				@(negedge pclk_tx);
				assert (!ready_tx_data_o)
				else note_failure(i, "host word taken without credit");
			end
			txwrite_tx_i = 1'b0;
		end
		else
			note_failure(i, "unknown action in stim file");
		act_done[i] = 1'b1;
		finish_record(i);
	endtask

	initial
	begin
		enable_tx = 1'b0;
		data_tx_i = '0;
		txwrite_tx_i = 1'b0;
		send_null_tx_i = 1'b0;
		send_fct_tx_i = 1'b0;
		gotfct_tx_i = 1'b0;
		send_fct_now_i = 1'b0;
		errors = 0;
		cycles = 0;
		limit = 0;
		ready_count = 0;
		write_count = 0;
		read_stim();
		if (nrec == 0)
		begin
			$display("No records could be read from the stim file");
			$display("Test failed");
		end
		else
		begin
			limit = 12 * nrec + 200;
			repeat (2) @(negedge pclk_tx);
			enable_tx = 1'b1;
			for (int i = 0; i < nrec; i++)
				run_record(i);
			// Drain what is still on its way to the line
			while (exp_code.size() != 0)
				@(negedge pclk_tx);
			repeat (4) @(negedge pclk_tx);
			assert (ready_count == write_count)
			else
			begin
				$display("[ERROR] ready pulses: expected %0d, actual %0d",
					write_count, ready_count);
				errors++;
			end
			errors += UUT.u_props.fails;
			$display("Records run: %0d, errors: %0d", nrec, errors);
			if (errors == 0)
				$display("Test passed");
			else
				$display("Test failed");
		end
		$finish;
	end

endmodule

/* tx_stim.txt */
# Columns: name action value exp0 exp1 exp2 exp3 (hex, fff marks an unused slot)
# Kinds: 000-0ff data, 101 EOP, 102 EEP, 103 FCT, 104 NULL
reset_idle quiet 014 fff fff fff fff
null_start send_null 000 104 104 104 104
null_start wait 028 fff fff fff fff
fct_init send_fct 000 103 103 103 103
fct_init wait 03c 103 103 103 104
fct_now fct_now 000 103 104 fff fff
no_credit stall 0a5 fff fff fff fff
data_flow gotfct 000 fff fff fff fff
data_flow write 011 011 fff fff fff
data_flow write 0c3 0c3 fff fff fff
data_flow write 07e 07e fff fff fff
data_flow write 0ff 0ff fff fff fff
data_flow write 000 000 fff fff fff
data_flow write 08e 08e fff fff fff
end_marks write 100 101 fff fff fff
end_marks write 101 102 fff fff fff
resume stall 03c fff fff fff fff
resume gotfct 000 fff fff fff fff
resume write 03c 03c fff fff fff
resume write 055 055 fff fff fff
resume write 100 101 fff fff fff

/* compile.f */
spw_tx_pkg.sv
char_if.sv
spw_tx_scheduler.sv
spw_char_fifo.sv
spw_tx_serializer.sv
spw_tx_top.sv
spw_tx_properties.sv
tb_spw_tx.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_spw_tx
OBJ_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
